// ==== tb/customInstrInput.txt ====
# start ciN ciDataA ciDataB stall busIdle, then expected cpuReset ciDone ciResult, all hex
# Lines 1 to 15 fall in the reset window after PLL lock, line 16 is the first released cycle
1 0b 00000000 0000000f 0 0 1 1 00000000
1 01 12345678 00000000 0 0 1 1 78563412
0 01 12345678 00000000 0 0 1 0 00000000
1 01 a1b2c3d4 00000000 0 0 1 1 d4c3b2a1
1 01 000000ff 00000000 0 0 1 1 ff000000
1 0c 0000ffff 00000000 0 0 1 1 0000ffdf
1 0c 00000000 00000000 0 0 1 1 00000000
1 0c 0000f800 00000000 0 0 1 1 000031a6
1 0c 000007e0 00000000 0 0 1 1 0000b5b6
1 0c 0000001f 00000000 0 0 1 1 00001082
1 0c 00008410 00000000 0 0 1 1 00008410
1 0c abcd1234 00000000 0 0 1 1 000039e7
1 02 12345678 00000000 0 0 1 0 00000000
1 0b 00000001 00000000 1 1 1 1 00000000
0 00 00000000 00000000 1 1 1 0 00000000
1 0b 00000000 0000000f 0 0 0 1 00000000
0 00 00000000 00000000 1 0 0 0 00000000
0 00 00000000 00000000 1 0 0 0 00000000
0 00 00000000 00000000 0 1 0 0 00000000
0 00 00000000 00000000 0 0 0 0 00000000
0 00 00000000 00000000 1 1 0 0 00000000
0 00 00000000 00000000 0 1 0 0 00000000
0 00 00000000 00000000 1 0 0 0 00000000
0 00 00000000 00000000 0 0 0 0 00000000
1 0b 00000000 00000000 0 0 0 1 00000008
1 0b 00000001 00000000 1 0 0 1 00000004
1 0b 00000002 00000000 0 0 0 1 00000003
1 0b 00000003 00000000 0 0 0 1 0000000b
1 0b 00000001 00000120 0 0 0 1 00000005
0 00 00000000 00000000 1 0 0 0 00000000
1 0b 00000001 00000000 1 0 0 1 00000005
1 0b 00000000 00000000 0 0 0 1 00000002
1 0b 00000003 00000000 0 0 0 1 00000010
1 0b 00000002 00000f00 0 1 0 1 00000003
1 0b 00000002 00000000 0 0 0 1 00000000
1 0b 00000000 00000000 0 0 0 1 00000001
1 ff 00000000 00000000 0 0 0 0 00000000
0 0b 00000003 00000000 0 0 0 0 00000000

// ==== list.f ====
hdl/customInstrPkg.sv
hdl/resetSequencer.sv
hdl/swapByteIse.sv
hdl/grayscaleIse.sv
hdl/profileCounterIse.sv
hdl/customInstrUnit.sv
tb/customInstrTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module customInstrTb -o customInstrSim

# The simulation exits non-zero on failure, the log decides the result
./obj_dir/customInstrSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

// ==== tb/customInstrTb.sv ====
`timescale 1ns/100ps

module customInstrTb;

  import customInstrPkg::*;

  localparam int clockPeriod = 40;
  localparam int resetCycles = 4;
  localparam int maxLines    = 64;
  localparam int fieldCount  = 9;  // start, ciN, A, B, stall, busIdle, cpuReset, done, result
  localparam logic [ciNumberWidth-1:0] unitNumbers [3] =
    '{swapByteId, grayscaleId, profileCounterId};

  logic                     s_systemClock;
  logic                     s_pllLocked;
  logic                     stall;
  logic                     busIdle;
  logic                     ciStart;
  logic [ciNumberWidth-1:0] ciN;
  logic [ciDataWidth-1:0]   ciDataA;
  logic [ciDataWidth-1:0]   ciDataB;
  logic                     cpuReset;
  logic                     ciDone;
  logic [ciDataWidth-1:0]   ciResult;

  logic [31:0] fields [maxLines][fieldCount];
  int          lineCount;
  bit          stimulusLoaded;

  customInstrUnit customInstrUnit_inst (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .stall         (stall),
    .busIdle       (busIdle),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .cpuReset      (cpuReset),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

  initial s_systemClock = 1'b0;
  always #(clockPeriod / 2) s_systemClock = ~s_systemClock;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abortRun(input string reason);
    $display("** Error at %0d ns: %s", $time, reason);
    $display("Some tests failed");
    $fatal(1, "Run aborted");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s expected %h, actual %h",
               $time, name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic readStimulus();
    int          fd;
    int          scanned;
    string       line;
    logic [31:0] value [fieldCount];
    lineCount = 0;
    fd = $fopen("tb/customInstrInput.txt", "r");
    if (fd == 0) begin
      abortRun("cannot open the stimulus file tb/customInstrInput.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
          continue;  // Column notes and blank lines
        end
        scanned = $sscanf(line, "%h %h %h %h %h %h %h %h %h", value[0], value[1],
                          value[2], value[3], value[4], value[5], value[6], value[7],
                          value[8]);
        if (scanned != fieldCount) begin
          abortRun("a line of the stimulus file does not hold nine hex fields");
        end else if (lineCount == maxLines) begin
          abortRun("the stimulus file holds more lines than the testbench stores");
        end else begin
          for (int f = 0; f < fieldCount; f++) begin
            fields[lineCount][f] = value[f];
          end
          lineCount++;
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic int countCalls(input logic [ciNumberWidth-1:0] number);
    int calls;
    calls = 0;
    for (int i = 0; i < lineCount; i++) begin
      if (fields[i][0][0] == 1'b1 && fields[i][1][ciNumberWidth-1:0] == number) begin
        calls++;
      end
    end
    return calls;
  endfunction

  task automatic applyLine(input int index);
    ciStart = fields[index][0][0];
    ciN     = fields[index][1][ciNumberWidth-1:0];
    ciDataA = fields[index][2];
    ciDataB = fields[index][3];
    stall   = fields[index][4][0];
    busIdle = fields[index][5][0];
  endtask

  task automatic checkLine(input int index);
    checkValue("cpuReset", fields[index][6], 32'(cpuReset));
    checkValue("ciDone", fields[index][7], 32'(ciDone));
    checkValue("ciResult", fields[index][8], ciResult);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    s_pllLocked    = 1'b0;
    stall          = 1'b0;
    busIdle        = 1'b0;
    ciStart        = 1'b0;
    ciN            = '0;
    ciDataA        = '0;
    ciDataB        = '0;
    stimulusLoaded = 1'b0;

    readStimulus();
    stimulusLoaded = 1'b1;
    if (countCalls(swapByteId) == 0 || countCalls(grayscaleId) == 0 ||
        countCalls(profileCounterId) == 0) begin
      abortRun("the stimulus file does not call every instruction unit");
    end

    // Each unit sees its own number without a start while the PLL is unlocked
    for (int i = 0; i < resetCycles - 1; i++) begin
      @(negedge s_systemClock);
      ciN     = unitNumbers[i % 3];
      ciDataA = 32'h0000_ffff;
      #(clockPeriod / 4);
      checkValue("cpuReset", 32'd1, 32'(cpuReset));  // PLL still unlocked
      checkValue("ciDone", 32'd0, 32'(ciDone));
      checkValue("ciResult", 32'd0, ciResult);
    end

    @(negedge s_systemClock);
    s_pllLocked = 1'b1;

    // Each line is applied at a falling edge and checked a quarter period later
    for (int i = 0; i < lineCount; i++) begin
      @(negedge s_systemClock);
      applyLine(i);
      #(clockPeriod / 4);
      checkLine(i);
    end

    $display("All tests passed");
    $finish;
  end

  initial begin
    wait (stimulusLoaded);
    #((resetCycles + lineCount + 40) * clockPeriod);
    $display("Simulation timed out before the last stimulus line was checked");
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== hdl/customInstrUnit.sv ====
`timescale 1ns/100ps

module customInstrUnit (
  input  logic                                   s_systemClock,
  input  logic                                   s_pllLocked,
  input  logic                                   stall,
  input  logic                                   busIdle,
  input  logic                                   ciStart,
  input  logic [customInstrPkg::ciNumberWidth-1:0] ciN,
  input  logic [customInstrPkg::ciDataWidth-1:0]   ciDataA,
  input  logic [customInstrPkg::ciDataWidth-1:0]   ciDataB,
  output logic                                   cpuReset,
  output logic                                   ciDone,
  output logic [customInstrPkg::ciDataWidth-1:0]   ciResult
);

  import customInstrPkg::*;

  logic                   swapByteDone;
  logic                   grayscaleDone;
  logic                   profileDone;
  logic [ciDataWidth-1:0] swapByteResult;
  logic [ciDataWidth-1:0] grayscaleResult;
  logic [ciDataWidth-1:0] profileResult;

  resetSequencer resetSequencer_inst (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .cpuReset      (cpuReset)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction units on the shared custom-instruction port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  swapByteIse swapByteIse_inst (
    .ciStart  (ciStart),
    .ciN      (ciN),
    .ciDataA  (ciDataA),
    .ciDone   (swapByteDone),
    .ciResult (swapByteResult)
  );

  grayscaleIse grayscaleIse_inst (
    .ciStart  (ciStart),
    .ciN      (ciN),
    .ciDataA  (ciDataA),
    .ciDone   (grayscaleDone),
    .ciResult (grayscaleResult)
  );

  profileCounterIse profileCounterIse_inst (
    .s_systemClock (s_systemClock),
    .cpuReset      (cpuReset),  // Counters held clear until release
    .stall         (stall),
    .busIdle       (busIdle),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .ciDone        (profileDone),
    .ciResult      (profileResult)
  );

  // Idle units answer zero, so a plain OR combines them
  assign ciDone   = swapByteDone | grayscaleDone | profileDone;
  assign ciResult = swapByteResult | grayscaleResult | profileResult;

endmodule

// ==== hdl/profileCounterIse.sv ====
`timescale 1ns/100ps

module profileCounterIse (
  input  logic                                   s_systemClock,
  input  logic                                   cpuReset,
  input  logic                                   stall,
  input  logic                                   busIdle,
  input  logic                                   ciStart,
  input  logic [customInstrPkg::ciNumberWidth-1:0] ciN,
  input  logic [customInstrPkg::ciDataWidth-1:0]   ciDataA,
  input  logic [customInstrPkg::ciDataWidth-1:0]   ciDataB,
  output logic                                   ciDone,
  output logic [customInstrPkg::ciDataWidth-1:0]   ciResult
);

  import customInstrPkg::*;

  logic                    selected;
  profileCounter_t         readSelect;
  logic [counterCount-1:0] counterEnable;
  logic [counterCount-1:0] countCondition;
  logic [counterCount-1:0] enableRequest;
  logic [counterCount-1:0] disableRequest;
  logic [counterCount-1:0] clearRequest;
  logic [ciDataWidth-1:0]  counterValue [counterCount];
  logic [ciDataWidth-1:0]  readValue;

  assign selected   = ciStart && (ciN == profileCounterId);
  assign readSelect = profileCounter_t'(ciDataA[1:0]);

  // Control fields only act on a start of this unit
  assign enableRequest  = selected ? ciDataB[enableLsb +: counterCount] : '0;
  assign disableRequest = selected ? ciDataB[disableLsb +: counterCount] : '0;
  assign clearRequest   = selected ? ciDataB[clearLsb +: counterCount] : '0;

  always_comb begin
    countCondition                  = '0;
    countCondition[cycleCount]      = 1'b1;
    countCondition[stallCount]      = stall;
    countCondition[busIdleCount]    = busIdle;
    countCondition[spareCycleCount] = 1'b1;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Enables and counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge s_systemClock) begin
    if (cpuReset) begin
      counterEnable <= '0;
    end else begin
      counterEnable <= (counterEnable | enableRequest) & ~disableRequest;  // Disable wins
    end
  end

  always_ff @(posedge s_systemClock) begin
    for (int i = 0; i < counterCount; i++) begin
      if (cpuReset || clearRequest[i]) begin
        counterValue[i] <= '0;  // Clear wins over counting
      end else if (counterEnable[i] && countCondition[i]) begin
        counterValue[i] <= counterValue[i] + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (readSelect)
      cycleCount:      readValue = counterValue[cycleCount];
      stallCount:      readValue = counterValue[stallCount];
      busIdleCount:    readValue = counterValue[busIdleCount];
      spareCycleCount: readValue = counterValue[spareCycleCount];
      default:         readValue = '0;
    endcase
  end

  assign ciDone   = selected;
  assign ciResult = selected ? readValue : '0;  // Value before the current edge

endmodule

// ==== hdl/grayscaleIse.sv ====
`timescale 1ns/100ps

module grayscaleIse (
  input  logic                                   ciStart,
  input  logic [customInstrPkg::ciNumberWidth-1:0] ciN,
  input  logic [customInstrPkg::ciDataWidth-1:0]   ciDataA,
  output logic                                   ciDone,
  output logic [customInstrPkg::ciDataWidth-1:0]   ciResult
);

  import customInstrPkg::*;

  logic                        selected;
  logic [grayWidth-1:0]        red;
  logic [grayWidth-1:0]        green;
  logic [grayWidth-1:0]        blue;
  logic [weightedSumWidth-1:0] weightedSum;
  logic [grayWidth-1:0]        gray;
  logic [ciDataWidth-1:0]      grayPixel;

  assign selected = ciStart && (ciN == grayscaleId);

  // RGB565 channels widened to 8 bits
  assign red   = {ciDataA[15:11], 3'b000};
  assign green = {ciDataA[10:5], 2'b00};
  assign blue  = {ciDataA[4:0], 3'b000};

  // Weights sum to 256, so the top byte is the gray level
  assign weightedSum = red * redWeight
                     + green * greenWeight
                     + blue * blueWeight;

  assign gray = weightedSum[weightedSumWidth-1 -: grayWidth];

  assign grayPixel = {16'd0, gray[7:3], gray[7:2], gray[7:3]};  // Repack as RGB565

  assign ciDone   = selected;
  assign ciResult = selected ? grayPixel : '0;

endmodule

// ==== hdl/swapByteIse.sv ====
`timescale 1ns/100ps

module swapByteIse (
  input  logic                                   ciStart,
  input  logic [customInstrPkg::ciNumberWidth-1:0] ciN,
  input  logic [customInstrPkg::ciDataWidth-1:0]   ciDataA,
  output logic                                   ciDone,
  output logic [customInstrPkg::ciDataWidth-1:0]   ciResult
);

  import customInstrPkg::*;

  logic                   selected;
  logic [ciDataWidth-1:0] swapped;

  assign selected = ciStart && (ciN == swapByteId);

  assign swapped = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};

  assign ciDone   = selected;
  assign ciResult = selected ? swapped : '0;  // Zero keeps the OR bus clean

endmodule

// ==== hdl/resetSequencer.sv ====
`timescale 1ns/100ps

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset
);

  import customInstrPkg::*;

  logic [resetCountWidth-1:0] resetCount;
  logic                       released;

  assign released = resetCount[resetCountWidth-1];
  assign cpuReset = ~released;

  // Saturates once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!released) begin
      resetCount <= resetCount + 1'b1;
    end
  end

endmodule

// ==== hdl/customInstrPkg.sv ====
package customInstrPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Custom-instruction port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int ciNumberWidth = 8;
  localparam int ciDataWidth   = 32;

  // Instruction numbers as in the system map
  localparam logic [ciNumberWidth-1:0] swapByteId       = 8'd1;
  localparam logic [ciNumberWidth-1:0] profileCounterId = 8'd11;
  localparam logic [ciNumberWidth-1:0] grayscaleId      = 8'd12;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reset sequencer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int resetCountWidth = 5;  // Top bit set after 16 clocks

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grayscale
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int grayWidth        = 8;
  localparam int weightedSumWidth = 16;  // 255 * 256 fits
  localparam logic [grayWidth-1:0] redWeight   = 8'd54;
  localparam logic [grayWidth-1:0] greenWeight = 8'd183;
  localparam logic [grayWidth-1:0] blueWeight  = 8'd19;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Profiling counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int counterCount = 4;
  localparam int enableLsb    = 0;  // Control field positions in ciDataB
  localparam int disableLsb   = 4;
  localparam int clearLsb     = 8;

  typedef enum logic [1:0] {
    cycleCount      = 2'd0,
    stallCount      = 2'd1,
    busIdleCount    = 2'd2,
    spareCycleCount = 2'd3
  } profileCounter_t;

endpackage
